// File: sim.f
isa_pkg.sv
core_pkg.sv
dispatch_cfg_regs.sv
inst_decoder.sv
inst_queue.sv
dispatch_top.sv
dispatch_props.sv
tb_clock.sv
tb_dispatch.sv

// File: tb_dispatch.sv
`timescale 1ns/1ps

module tb_dispatch;

    localparam int IQ_DEPTH    = core_pkg::DEFAULT_IQ_DEPTH;
    localparam int RAND_WORDS  = 300;
    localparam int WORDS_TOTAL = 8 + 8 + 9 + IQ_DEPTH + 10 + RAND_WORDS;

    typedef struct packed {
        isa_pkg::op_t              op;
        logic [isa_pkg::REG_W-1:0] rs1;
        logic [isa_pkg::REG_W-1:0] rs2;
        logic [isa_pkg::REG_W-1:0] rd;
        logic [31:0]               imm;
        logic                      has_imm;
    } exp_t;

    logic                      clk;
    logic                      rst;
    logic                      inst_valid;
    isa_pkg::inst_word_u       inst_word;
    logic                      cfg_we;
    logic [1:0]                cfg_addr;
    logic [31:0]               cfg_wdata;
    logic                      rs_full;
    logic                      rob_full;
    logic                      iq_full;
    logic                      issue_valid;
    isa_pkg::op_t              issue_op;
    logic [isa_pkg::REG_W-1:0] issue_rs1;
    logic [isa_pkg::REG_W-1:0] issue_rs2;
    logic [isa_pkg::REG_W-1:0] issue_rd;
    logic [31:0]               issue_imm;
    logic                      issue_has_imm;

    exp_t        exp_q[$];
    logic [31:0] lfsr = 32'h360;
    logic        paused;

    tb_clock #(.PERIOD(4), .RST_CYCLES(5)) u_clk (.clk(clk), .rst(rst));

    dispatch_top #(.IQ_DEPTH(IQ_DEPTH)) dut (.*);

    bind inst_queue dispatch_props u_props (.*);

    // --------------------------------------------------
    // reference model and stimulus helpers
    // --------------------------------------------------

    // taps 32, 22, 2, 1.
    function automatic logic lfsr_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w = {w[30:0], lfsr_bit()};
        end
        return w;
    endfunction

    function automatic logic opcode_is_valid(logic [4:0] op);
        return (op <= 5'd6) || (op >= 5'd16 && op <= 5'd20);
    endfunction

    function automatic exp_t decode_expected(logic [31:0] w);
        exp_t e;
        e.op      = w[31:27];
        e.rd      = w[26:22];
        e.rs1     = w[21:17];
        e.has_imm = (w[31:27] >= 5'd16);
        e.rs2     = e.has_imm ? 5'd0 : w[16:12];
        e.imm     = e.has_imm ? {{15{w[16]}}, w[16:0]} : 32'd0;
        return e;
    endfunction

    function automatic logic [31:0] r_type_word(logic [4:0] op, rd, rs1, rs2);
        return {op, rd, rs1, rs2, 12'h000};
    endfunction

    function automatic logic [31:0] i_type_word(logic [4:0] op, rd, rs1, logic [16:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    task automatic report_failure(string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_op(string name, isa_pkg::op_t exp, isa_pkg::op_t act);
        if (exp !== act) begin
            report_failure($sformatf("ERR at %0t: %s expected %0d got %0d",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_reg(string name, logic [isa_pkg::REG_W-1:0] exp,
                             logic [isa_pkg::REG_W-1:0] act);
        if (exp !== act) begin
            report_failure($sformatf("ERR at %0t: %s expected %0d got %0d",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_imm(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            report_failure($sformatf("ERR at %0t: %s expected 0x%08h got 0x%08h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            report_failure($sformatf("ERR at %0t: %s expected %b got %b",
                                     $time, name, exp, act));
        end
    endtask

    // called on a falling edge, returns on the next one.
    task automatic send_word(logic [31:0] w, logic v);
        inst_valid = v;
        inst_word  = w;
        if (v && !paused && opcode_is_valid(w[31:27])) begin
            exp_q.push_back(decode_expected(w));
        end
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic cfg_write(logic [1:0] addr, logic [31:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (n > 4 * IQ_DEPTH + 40) begin
                report_failure("queued instructions did not issue in time");
            end
            @(negedge clk);
            n++;
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic expect_issues(int n);
        repeat (n) begin
            @(negedge clk);
            check_bit("issue_valid", 1'b1, issue_valid);
        end
    endtask

    // --------------------------------------------------
    // issue monitor and watchdog
    // --------------------------------------------------

    always @(negedge clk) begin : monitor
        exp_t e;
        if (rst && issue_valid) begin
            if (exp_q.size() == 0) begin
                report_failure("issue_valid pulsed with no instruction expected");
            end else begin
                e = exp_q.pop_front();
                check_op("issue_op", e.op, issue_op);
                check_reg("issue_rs1", e.rs1, issue_rs1);
                check_reg("issue_rs2", e.rs2, issue_rs2);
                check_reg("issue_rd", e.rd, issue_rd);
                check_imm("issue_imm", e.imm, issue_imm);
                check_bit("issue_has_imm", e.has_imm, issue_has_imm);
            end
        end
    end

    // 60 ns per word sent plus 2 us of margin.
    initial begin
        #(WORDS_TOTAL * 60 + 2000);
        report_failure("watchdog expired before the tests finished");
    end

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------

    task automatic test_basic_issue();
        send_word(r_type_word(isa_pkg::OP_ADD, 5'd3, 5'd1, 5'd2), 1'b1);
        check_bit("issue_valid", 1'b0, issue_valid);
        @(negedge clk);
        check_bit("issue_valid", 1'b0, issue_valid);
        @(negedge clk);
        check_bit("issue_valid", 1'b1, issue_valid);
        send_word(i_type_word(isa_pkg::OP_ADDI, 5'd4, 5'd5, 17'h1ffff), 1'b1);
        send_word(r_type_word(isa_pkg::OP_SUB, 5'd31, 5'd30, 5'd29), 1'b1);
        send_word(i_type_word(isa_pkg::OP_LW, 5'd7, 5'd8, 17'h10000), 1'b1);
        send_word(r_type_word(isa_pkg::OP_XOR, 5'd9, 5'd10, 5'd11), 1'b1);
        send_word(i_type_word(isa_pkg::OP_ORI, 5'd12, 5'd13, 17'h0abcd), 1'b1);
        send_word(r_type_word(isa_pkg::OP_SRL, 5'd14, 5'd15, 5'd16), 1'b1);
        send_word(i_type_word(isa_pkg::OP_SW, 5'd17, 5'd18, 17'h1fff0), 1'b1);
        wait_drain();
    endtask

    task automatic test_invalid_ops();
        send_word(r_type_word(isa_pkg::OP_AND, 5'd1, 5'd2, 5'd3), 1'b1);
        send_word(r_type_word(5'd7, 5'd4, 5'd5, 5'd6), 1'b1);
        send_word(i_type_word(5'd21, 5'd4, 5'd5, 17'h00042), 1'b1);
        send_word(r_type_word(5'd15, 5'd6, 5'd7, 5'd8), 1'b1);
        send_word(i_type_word(isa_pkg::OP_NOP, 5'd9, 5'd9, 17'h00009), 1'b1);
        send_word(r_type_word(isa_pkg::OP_OR, 5'd10, 5'd11, 5'd12), 1'b0);
        send_word(i_type_word(isa_pkg::OP_ANDI, 5'd13, 5'd14, 17'h00123), 1'b1);
        send_word(r_type_word(isa_pkg::OP_SLL, 5'd15, 5'd16, 5'd17), 1'b1);
        wait_drain();
    endtask

    // rs_full alone, rob_full alone, then both.
    task automatic test_backpressure();
        isa_pkg::op_t held_op;
        logic [31:0]  held_imm;
        for (int mode = 1; mode <= 3; mode++) begin
            rs_full  = mode[0];
            rob_full = mode[1];
            held_op  = issue_op;
            held_imm = issue_imm;
            for (int k = 0; k < 3; k++) begin
                send_word(i_type_word(isa_pkg::OP_ADDI, 5'(mode), 5'(k),
                                      17'(k * 1000 - 1500)), 1'b1);
            end
            repeat (4) begin
                @(negedge clk);
                check_bit("issue_valid", 1'b0, issue_valid);
                check_op("issue_op", held_op, issue_op);
                check_imm("issue_imm", held_imm, issue_imm);
            end
            rs_full  = 1'b0;
            rob_full = 1'b0;
            expect_issues(3);
        end
        wait_drain();
    endtask

    task automatic test_fill();
        int sent;
        sent    = 0;
        rs_full = 1'b1;
        while (!iq_full) begin
            if (sent > 2 * IQ_DEPTH) begin
                report_failure("iq_full never rose while the queue was filled");
            end
            send_word(r_type_word(isa_pkg::OP_ADD, 5'(sent), 5'(sent + 1), 5'(sent + 2)), 1'b1);
            sent++;
        end
        if (sent != IQ_DEPTH) begin
            report_failure($sformatf("iq_full rose after %0d words instead of %0d",
                                     sent, IQ_DEPTH));
        end
        repeat (2) @(negedge clk);
        check_bit("iq_full", 1'b1, iq_full);
        rs_full = 1'b0;
        expect_issues(IQ_DEPTH);
        check_bit("iq_full", 1'b0, iq_full);
        wait_drain();
    endtask

    task automatic test_pause_flush();
        rs_full = 1'b1;
        for (int k = 0; k < 4; k++) begin
            send_word(i_type_word(isa_pkg::OP_ORI, 5'(k), 5'(k + 8), 17'(k)), 1'b1);
        end
        repeat (2) @(negedge clk);
        cfg_write(core_pkg::CFG_ADDR_CTRL, 32'h1);
        paused  = 1'b1;
        rs_full = 1'b0;
        send_word(r_type_word(isa_pkg::OP_ADD, 5'd1, 5'd1, 5'd1), 1'b1);
        repeat (6) begin
            @(negedge clk);
            check_bit("issue_valid", 1'b0, issue_valid);
        end
        // the word offered while paused must not follow the queued ones.
        cfg_write(core_pkg::CFG_ADDR_CTRL, 32'h0);
        paused = 1'b0;
        wait_drain();
        rs_full = 1'b1;
        for (int k = 0; k < 4; k++) begin
            send_word(i_type_word(isa_pkg::OP_ANDI, 5'(k + 4), 5'(k), 17'(k + 5)), 1'b1);
        end
        repeat (2) @(negedge clk);
        // queued entries are discarded along with the model.
        cfg_write(core_pkg::CFG_ADDR_FLUSH, 32'h0);
        exp_q.delete();
        rs_full = 1'b0;
        repeat (6) begin
            @(negedge clk);
            check_bit("issue_valid", 1'b0, issue_valid);
        end
        check_bit("iq_full", 1'b0, iq_full);
        send_word(r_type_word(isa_pkg::OP_OR, 5'd2, 5'd3, 5'd4), 1'b1);
        wait_drain();
    endtask

    task automatic test_random();
        int sent;
        sent = 0;
        while (sent < RAND_WORDS) begin
            rs_full  = lfsr_bit();
            rob_full = lfsr_bit();
            if (!iq_full && lfsr_bit()) begin
                send_word(random_word(), 1'b1);
                sent++;
            end else begin
                @(negedge clk);
            end
        end
        rs_full  = 1'b0;
        rob_full = 1'b0;
        wait_drain();
    endtask

    initial begin
        inst_valid = 1'b0;
        inst_word  = '0;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        rs_full    = 1'b0;
        rob_full   = 1'b0;
        paused     = 1'b0;
        @(posedge rst);
        @(negedge clk);
        test_basic_issue();
        test_invalid_ops();
        test_backpressure();
        test_fill();
        test_pause_flush();
        test_random();
        repeat (4) @(negedge clk);
        if (dut.u_iq.u_props.err_count != 0) begin
            report_failure("a concurrent assertion on the queue failed");
        end else if (exp_q.size() != 0) begin
            report_failure("instructions were lost");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD     = 4,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released on a falling edge, away from the sampling edge.
    initial begin
        rst = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

// File: dispatch_props.sv
`timescale 1ns/1ps

module dispatch_props (
    input logic         clk,
    input logic         rst,
    input logic         pause,
    input logic         flush,
    input logic         rs_full,
    input logic         rob_full,
    input logic         iq_full,
    input logic         issue_valid,
    input isa_pkg::op_t dec_op
);

    int err_count = 0;

    // a stalled or paused edge never produces an issue.
    assert property (@(posedge clk) disable iff (!rst)
        (rs_full || rob_full || pause) |=> !issue_valid)
        else begin
            $error("issue_valid set after a stalled edge");
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!rst) flush |=> !iq_full)
        else begin
            $error("iq_full still high one cycle after flush");
            err_count++;
        end

    // once full for two edges, the spare slot has been used and no new word arrives.
    assert property (@(posedge clk) disable iff (!rst)
        (iq_full && $past(iq_full) && !pause) |-> (dec_op == isa_pkg::OP_NOP))
        else begin
            $error("instruction reached the queue while iq_full was high");
            err_count++;
        end

endmodule

// File: dispatch_top.sv
`timescale 1ns/1ps

module dispatch_top #(
    parameter int IQ_DEPTH = core_pkg::DEFAULT_IQ_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inst_valid,
    input  isa_pkg::inst_word_u       inst_word,
    input  logic                      cfg_we,
    input  logic [1:0]                cfg_addr,
    input  logic [31:0]               cfg_wdata,
    input  logic                      rs_full,
    input  logic                      rob_full,
    output logic                      iq_full,
    output logic                      issue_valid,
    output isa_pkg::op_t              issue_op,
    output logic [isa_pkg::REG_W-1:0] issue_rs1,
    output logic [isa_pkg::REG_W-1:0] issue_rs2,
    output logic [isa_pkg::REG_W-1:0] issue_rd,
    output logic [31:0]               issue_imm,
    output logic                      issue_has_imm
);

    logic                      pause;
    logic                      flush;
    isa_pkg::op_t              dec_op;
    logic [isa_pkg::REG_W-1:0] dec_rs1;
    logic [isa_pkg::REG_W-1:0] dec_rs2;
    logic [isa_pkg::REG_W-1:0] dec_rd;
    logic [31:0]               dec_imm;
    logic                      dec_has_imm;

    dispatch_cfg_regs u_cfg (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .pause     (pause),
        .flush     (flush)
    );

    inst_decoder u_dec (
        .clk         (clk),
        .rst         (rst),
        .pause       (pause),
        .flush       (flush),
        .inst_valid  (inst_valid),
        .inst_word   (inst_word),
        .dec_op      (dec_op),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_rd      (dec_rd),
        .dec_imm     (dec_imm),
        .dec_has_imm (dec_has_imm)
    );

    inst_queue #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_iq (
        .clk           (clk),
        .rst           (rst),
        .pause         (pause),
        .flush         (flush),
        .dec_op        (dec_op),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .dec_rd        (dec_rd),
        .dec_imm       (dec_imm),
        .dec_has_imm   (dec_has_imm),
        .rs_full       (rs_full),
        .rob_full      (rob_full),
        .iq_full       (iq_full),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_rd      (issue_rd),
        .issue_imm     (issue_imm),
        .issue_has_imm (issue_has_imm)
    );

endmodule

// File: inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
    parameter int IQ_DEPTH = 16
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pause,
    input  logic                      flush,
    input  isa_pkg::op_t              dec_op,
    input  logic [isa_pkg::REG_W-1:0] dec_rs1,
    input  logic [isa_pkg::REG_W-1:0] dec_rs2,
    input  logic [isa_pkg::REG_W-1:0] dec_rd,
    input  logic [31:0]               dec_imm,
    input  logic                      dec_has_imm,
    input  logic                      rs_full,
    input  logic                      rob_full,
    output logic                      iq_full,
    output logic                      issue_valid,
    output isa_pkg::op_t              issue_op,
    output logic [isa_pkg::REG_W-1:0] issue_rs1,
    output logic [isa_pkg::REG_W-1:0] issue_rs2,
    output logic [isa_pkg::REG_W-1:0] issue_rd,
    output logic [31:0]               issue_imm,
    output logic                      issue_has_imm
);

    localparam int PTR_W = $clog2(IQ_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    isa_pkg::op_t              op_mem      [IQ_DEPTH];
    logic [isa_pkg::REG_W-1:0] rs1_mem     [IQ_DEPTH];
    logic [isa_pkg::REG_W-1:0] rs2_mem     [IQ_DEPTH];
    logic [isa_pkg::REG_W-1:0] rd_mem      [IQ_DEPTH];
    logic [31:0]               imm_mem     [IQ_DEPTH];
    logic                      has_imm_mem [IQ_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;
    logic             at_cap;
    logic             do_enq;
    logic             do_issue;

    // --------------------------------------------------
    // enqueue and issue decisions
    // --------------------------------------------------

    assign at_cap = (count == CNT_W'(IQ_DEPTH));

    // head is issued only when both downstream units have room.
    assign do_issue = !pause && !flush && !rs_full && !rob_full && (count != '0);

    // a full queue still accepts when the head leaves on the same edge.
    assign do_enq = !pause && !flush && (dec_op != isa_pkg::OP_NOP) && (!at_cap || do_issue);

    always_comb begin
        count_nxt = count;
        case ({do_enq, do_issue})
            2'b10:   count_nxt = count + 1'b1;
            2'b01:   count_nxt = count - 1'b1;
            default: count_nxt = count;
        endcase
    end

    // --------------------------------------------------
    // entry storage
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (do_enq) begin
            op_mem[tail]      <= dec_op;
            rs1_mem[tail]     <= dec_rs1;
            rs2_mem[tail]     <= dec_rs2;
            rd_mem[tail]      <= dec_rd;
            imm_mem[tail]     <= dec_imm;
            has_imm_mem[tail] <= dec_has_imm;
        end
    end

    // --------------------------------------------------
    // pointers, occupancy and full flag
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            iq_full <= 1'b0;
        end else if (flush) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            iq_full <= 1'b0;
        end else begin
            if (do_enq) begin
                tail <= tail + 1'b1;
            end
            if (do_issue) begin
                head <= head + 1'b1;
            end
            count <= count_nxt;
            // one slot kept spare for the word still in decode.
            iq_full <= (count_nxt >= CNT_W'(IQ_DEPTH - 1));
        end
    end

    // --------------------------------------------------
    // issue registers
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst) begin
            issue_valid <= 1'b0;
            issue_op    <= isa_pkg::OP_NOP;
        end else if (flush) begin
            issue_valid <= 1'b0;
            issue_op    <= isa_pkg::OP_NOP;
        end else begin
            issue_valid <= do_issue;
            if (do_issue) begin
                issue_op <= op_mem[head];
            end
        end
    end

    // held while stalled.
    always_ff @(posedge clk) begin
        if (do_issue) begin
            issue_rs1     <= rs1_mem[head];
            issue_rs2     <= rs2_mem[head];
            issue_rd      <= rd_mem[head];
            issue_imm     <= imm_mem[head];
            issue_has_imm <= has_imm_mem[head];
        end
    end

endmodule

// File: inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pause,
    input  logic                      flush,
    input  logic                      inst_valid,
    input  isa_pkg::inst_word_u       inst_word,
    output isa_pkg::op_t              dec_op,
    output logic [isa_pkg::REG_W-1:0] dec_rs1,
    output logic [isa_pkg::REG_W-1:0] dec_rs2,
    output logic [isa_pkg::REG_W-1:0] dec_rd,
    output logic [31:0]               dec_imm,
    output logic                      dec_has_imm
);

    isa_pkg::op_t              raw_op;
    logic                      op_ok;
    logic                      is_i;
    isa_pkg::op_t              nxt_op;
    logic [isa_pkg::REG_W-1:0] nxt_rs1;
    logic [isa_pkg::REG_W-1:0] nxt_rs2;
    logic [isa_pkg::REG_W-1:0] nxt_rd;
    logic [31:0]               nxt_imm;
    logic                      nxt_has_imm;

    // --------------------------------------------------
    // field extraction
    // --------------------------------------------------

    always_comb begin
        // opcode, rd and rs1 sit in the same bits in both views.
        raw_op  = inst_word.r.op;
        op_ok   = isa_pkg::is_valid_op(raw_op);
        is_i    = op_ok && (raw_op >= isa_pkg::OP_ADDI);
        nxt_op  = (inst_valid && op_ok) ? raw_op : isa_pkg::OP_NOP;
        nxt_rd  = inst_word.r.rd;
        nxt_rs1 = inst_word.r.rs1;

        if (is_i) begin
            nxt_rs2     = '0;
            nxt_imm     = {{15{inst_word.i.imm17[16]}}, inst_word.i.imm17};
            nxt_has_imm = 1'b1;
        end else begin
            nxt_rs2     = inst_word.r.rs2;
            nxt_imm     = '0;
            nxt_has_imm = 1'b0;
        end
    end

    // --------------------------------------------------
    // decode register stage
    // --------------------------------------------------

    // an empty cycle or a flush leaves a nop in the stage.
    always_ff @(posedge clk) begin
        if (!rst) begin
            dec_op <= isa_pkg::OP_NOP;
        end else if (flush) begin
            dec_op <= isa_pkg::OP_NOP;
        end else if (!pause) begin
            dec_op <= nxt_op;
        end
    end

    // fields only matter when dec_op is not a nop.
    always_ff @(posedge clk) begin
        if (!pause) begin
            dec_rs1     <= nxt_rs1;
            dec_rs2     <= nxt_rs2;
            dec_rd      <= nxt_rd;
            dec_imm     <= nxt_imm;
            dec_has_imm <= nxt_has_imm;
        end
    end

endmodule

// File: dispatch_cfg_regs.sv
`timescale 1ns/1ps

module dispatch_cfg_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        cfg_we,
    input  logic [1:0]  cfg_addr,
    input  logic [31:0] cfg_wdata,
    output logic        pause,
    output logic        flush
);

    logic ctrl_wr;
    logic flush_wr;

    // --------------------------------------------------
    // write decode
    // --------------------------------------------------

    assign ctrl_wr  = cfg_we && (cfg_addr == core_pkg::CFG_ADDR_CTRL);
    assign flush_wr = cfg_we && (cfg_addr == core_pkg::CFG_ADDR_FLUSH);

    // --------------------------------------------------
    // control state
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst) begin
            pause <= 1'b0;
        end else if (ctrl_wr) begin
            pause <= cfg_wdata[core_pkg::CFG_PAUSE_BIT];
        end
    end

    // single cycle pulse, data bits are ignored.
    always_ff @(posedge clk) begin
        if (!rst) begin
            flush <= 1'b0;
        end else begin
            flush <= flush_wr;
        end
    end

endmodule

// File: core_pkg.sv
package core_pkg;

    // --------------------------------------------------
    // instruction queue sizing
    // --------------------------------------------------

    // must be a power of two.
    localparam int DEFAULT_IQ_DEPTH = 16;

    // --------------------------------------------------
    // configuration register map
    // --------------------------------------------------

    localparam int CFG_ADDR_W = 2;

    // control register, pause in bit 0.
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_CTRL  = 2'd0;

    // any write here flushes the front end.
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_FLUSH = 2'd1;

    localparam int CFG_PAUSE_BIT = 0;

endpackage

// File: isa_pkg.sv
package isa_pkg;

    // --------------------------------------------------
    // opcode space
    // --------------------------------------------------

    localparam int REG_W = 5;

    typedef logic [4:0] op_t;

    // register-register group.
    localparam op_t OP_ADD  = 5'd0;
    localparam op_t OP_SUB  = 5'd1;
    localparam op_t OP_AND  = 5'd2;
    localparam op_t OP_OR   = 5'd3;
    localparam op_t OP_XOR  = 5'd4;
    localparam op_t OP_SLL  = 5'd5;
    localparam op_t OP_SRL  = 5'd6;

    // immediate group, all at 16 and above.
    localparam op_t OP_ADDI = 5'd16;
    localparam op_t OP_ANDI = 5'd17;
    localparam op_t OP_ORI  = 5'd18;
    localparam op_t OP_LW   = 5'd19;
    localparam op_t OP_SW   = 5'd20;

    // empty slot marker.
    localparam op_t OP_NOP  = 5'd31;

    // --------------------------------------------------
    // instruction word layouts
    // --------------------------------------------------

    typedef union packed {
        struct packed {
            op_t              op;
            logic [REG_W-1:0] rd;
            logic [REG_W-1:0] rs1;
            logic [REG_W-1:0] rs2;
            logic [11:0]      unused;
        } r;
        struct packed {
            op_t              op;
            logic [REG_W-1:0] rd;
            logic [REG_W-1:0] rs1;
            logic [16:0]      imm17;
        } i;
    } inst_word_u;

    // true only for implemented opcodes, nop excluded.
    function automatic logic is_valid_op(op_t op);
        logic ok;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL: ok = 1'b1;
            OP_ADDI, OP_ANDI, OP_ORI, OP_LW, OP_SW:                ok = 1'b1;
            default:                                               ok = 1'b0;
        endcase
        return ok;
    endfunction

endpackage
